/* verilog/mm_pkg.sv */
`default_nettype none

package mm_pkg;

    // Board geometry
    localparam int NUM_PEGS   = 4;
    localparam int PEG_W      = 3;
    localparam int SEG_W      = 7;
    localparam int NUM_DIGITS = 6;

    localparam int SLOT_W  = $clog2(NUM_PEGS);
    localparam int COUNT_W = $clog2(NUM_PEGS) + 1;   // Holds 0 to NUM_PEGS

    typedef logic [PEG_W-1:0]   peg_t;
    typedef peg_t [NUM_PEGS-1:0] peg_row_t;          // Slot 0 entered first
    typedef logic [SLOT_W-1:0]  slot_t;
    typedef logic [COUNT_W-1:0] count_t;
    typedef logic [SEG_W-1:0]   seg_t;               // Active low, segment a in bit 0

    localparam slot_t LAST_SLOT = slot_t'(NUM_PEGS - 1);

    typedef struct packed {
        count_t red;
        count_t white;
    } score_t;

    // Row write request, one cycle per press
    typedef struct packed {
        logic  load_code;
        logic  load_guess;
        slot_t slot;
    } entry_cmd_t;

    typedef struct packed {
        logic  clear;
        logic  step;
        slot_t slot;
    } cmp_cmd_t;

    typedef enum logic [2:0] {
        CODE_PEG,
        CODE_WAIT,
        GUESS_PEG,
        GUESS_WAIT,
        COMPARE,
        REPORT
    } mm_state_e;

endpackage

`default_nettype wire

/* verilog/mm_seven_seg.sv */
`default_nettype none
`timescale 1ns/1ps

module mm_seven_seg
    import mm_pkg::*;
(
    input  logic [3:0] digit_i,
    output seg_t       segments_o
);

    // Active low, bit 0 is segment a
    always_comb begin
        case (digit_i)
            4'h0: segments_o = 7'b100_0000;
            4'h1: segments_o = 7'b111_1001;
            4'h2: segments_o = 7'b010_0100;
            4'h3: segments_o = 7'b011_0000;
            4'h4: segments_o = 7'b001_1001;
            4'h5: segments_o = 7'b001_0010;
            4'h6: segments_o = 7'b000_0010;
            4'h7: segments_o = 7'b111_1000;
            4'h8: segments_o = 7'b000_0000;
            4'h9: segments_o = 7'b001_1000;
            4'hA: segments_o = 7'b000_1000;
            4'hB: segments_o = 7'b000_0011;
            4'hC: segments_o = 7'b100_0110;
            4'hD: segments_o = 7'b010_0001;
            4'hE: segments_o = 7'b000_0110;
            4'hF: segments_o = 7'b000_1110;
            default: segments_o = '1;   // Blank
        endcase
    end

endmodule

`default_nettype wire

/* verilog/mm_control.sv */
`default_nettype none
`timescale 1ns/1ps

module mm_control
    import mm_pkg::*;
(
    input  logic       clock,
    input  logic       resetn,
    input  logic       load_i,
    output entry_cmd_t entry_o,
    output cmp_cmd_t   cmp_o,
    output logic       score_valid_o
);

    mm_state_e state;
    mm_state_e next_state;
    slot_t     slot;
    slot_t     next_slot;
    logic      last_slot;

    assign last_slot = (slot == LAST_SLOT);

    // Slot wraps back to 0 after the last peg, ready for the next phase
    always_comb begin
        next_state = state;
        next_slot  = slot;
        case (state)
            CODE_PEG: begin
                if (load_i) begin
                    next_state = CODE_WAIT;
                end
            end
            CODE_WAIT: begin
                if (!load_i) begin
                    next_slot  = slot + 1'b1;
                    next_state = last_slot ? GUESS_PEG : CODE_PEG;
                end
            end
            GUESS_PEG: begin
                if (load_i) begin
                    next_state = GUESS_WAIT;
                end
            end
            GUESS_WAIT: begin
                if (!load_i) begin
                    next_slot  = slot + 1'b1;
                    next_state = last_slot ? COMPARE : GUESS_PEG;
                end
            end
            COMPARE: begin
                next_slot = slot + 1'b1;
                if (last_slot) begin
                    next_state = REPORT;
                end
            end
            REPORT: begin
                next_state = GUESS_PEG;   // Code is kept, only guesses repeat
            end
            default: begin
                next_state = CODE_PEG;
                next_slot  = '0;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state         <= CODE_PEG;
            slot          <= '0;
            entry_o       <= '0;
            cmp_o         <= '0;
            score_valid_o <= 1'b0;
        end else begin
            state <= next_state;
            slot  <= next_slot;

            // One strobe per press, only on leaving the PEG state
            entry_o.load_code  <= load_i && (state == CODE_PEG);
            entry_o.load_guess <= load_i && (state == GUESS_PEG);
            entry_o.slot       <= slot;

            cmp_o.clear <= load_i && (state == GUESS_PEG) && last_slot;
            cmp_o.step  <= (next_state == COMPARE);   // Aligned with the COMPARE cycles
            cmp_o.slot  <= next_slot;

            score_valid_o <= (next_state == REPORT);
        end
    end

    // Code and guess rows are never written by the same press
    a_one_row: assert property (
        @(posedge clock) disable iff (!resetn)
        !(entry_o.load_code && entry_o.load_guess)
    );

    // Scorer only steps while the FSM sits in COMPARE
    a_step_in_compare: assert property (
        @(posedge clock) disable iff (!resetn)
        cmp_o.step |-> (state == COMPARE) && (cmp_o.slot == slot)
    );

endmodule

`default_nettype wire

/* verilog/mm_peg_regs.sv */
`default_nettype none
`timescale 1ns/1ps

module mm_peg_regs
    import mm_pkg::*;
(
    input  logic       clock,
    input  logic       resetn,
    input  entry_cmd_t entry_i,
    input  peg_t       colour_i,
    output peg_row_t   code_o,
    output peg_row_t   guess_o
);

    peg_t                colour_q;
    logic [NUM_PEGS-1:0] code_we;
    logic [NUM_PEGS-1:0] guess_we;

    // The strobe trails the press edge by a cycle, so the colour trails with it
    always_ff @(posedge clock) begin
        colour_q <= colour_i;
    end

    // Per-slot write enables
    always_comb begin
        code_we  = '0;
        guess_we = '0;
        code_we[entry_i.slot]  = entry_i.load_code;
        guess_we[entry_i.slot] = entry_i.load_guess;
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            code_o  <= '0;
            guess_o <= '0;
        end else begin
            for (int k = 0; k < NUM_PEGS; k++) begin
                if (code_we[k]) begin
                    code_o[k] <= colour_q;
                end
                if (guess_we[k]) begin
                    guess_o[k] <= colour_q;   // Held until overwritten by the next guess
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/mm_scorer.sv */
`default_nettype none
`timescale 1ns/1ps

module mm_scorer
    import mm_pkg::*;
(
    input  logic     clock,
    input  logic     resetn,
    input  cmp_cmd_t cmp_i,
    input  peg_row_t code_i,
    input  peg_row_t guess_i,
    output score_t   score_o
);

    logic [NUM_PEGS-1:0] exact;       // guess[k] == code[k]
    logic [NUM_PEGS-1:0] used;        // Guess pegs already scored white
    logic [NUM_PEGS-1:0] candidate;
    logic [NUM_PEGS-1:0] pick;
    peg_t                code_peg;
    logic [COUNT_W:0]    score_sum;

    assign code_peg = code_i[cmp_i.slot];

    always_comb begin
        for (int k = 0; k < NUM_PEGS; k++) begin
            exact[k]     = (guess_i[k] == code_i[k]);
            candidate[k] = !used[k] && !exact[k] && (guess_i[k] == code_peg);
        end
    end

    // Isolate lowest set bit, so the lowest free position wins
    assign pick = candidate & (~candidate + 1'b1);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            used    <= '0;
            score_o <= '0;
        end else if (cmp_i.clear) begin
            used    <= '0;
            score_o <= '0;
        end else if (cmp_i.step) begin
            if (exact[cmp_i.slot]) begin
                score_o.red <= score_o.red + 1'b1;
            end else if (|pick) begin
                used          <= used | pick;
                score_o.white <= score_o.white + 1'b1;
            end
        end
    end

    assign score_sum = score_o.red + score_o.white;

    // Each code peg contributes at most one red or white over a round
    a_score_bound: assert property (
        @(posedge clock) disable iff (!resetn)
        score_sum <= NUM_PEGS
    );

endmodule

`default_nettype wire

/* verilog/mastermind_top.sv */
`default_nettype none
`timescale 1ns/1ps

module mastermind_top
    import mm_pkg::*;
(
    input  logic                  clock,
    input  logic                  resetn,
    input  logic                  load_i,
    input  peg_t                  colour_i,
    output seg_t [NUM_DIGITS-1:0] hex_o,
    output score_t                score_o,
    output logic                  score_valid_o
);

    entry_cmd_t entry;
    cmp_cmd_t   cmp;
    peg_row_t   code;
    peg_row_t   guess;
    logic [3:0] digit [NUM_DIGITS];

    mm_control control_inst (
        .clock         (clock),
        .resetn        (resetn),
        .load_i        (load_i),
        .entry_o       (entry),
        .cmp_o         (cmp),
        .score_valid_o (score_valid_o)
    );

    mm_peg_regs peg_regs_inst (
        .clock    (clock),
        .resetn   (resetn),
        .entry_i  (entry),
        .colour_i (colour_i),
        .code_o   (code),
        .guess_o  (guess)
    );

    mm_scorer scorer_inst (
        .clock   (clock),
        .resetn  (resetn),
        .cmp_i   (cmp),
        .code_i  (code),
        .guess_i (guess),
        .score_o (score_o)
    );

    // Guess pegs on digits 0 to 3, then red and white
    always_comb begin
        for (int k = 0; k < NUM_PEGS; k++) begin
            digit[k] = {1'b0, guess[k]};
        end
        digit[NUM_PEGS]     = {1'b0, score_o.red};
        digit[NUM_PEGS + 1] = {1'b0, score_o.white};
    end

    for (genvar d = 0; d < NUM_DIGITS; d++) begin : g_hex
        mm_seven_seg seven_seg_inst (
            .digit_i    (digit[d]),
            .segments_o (hex_o[d])
        );
    end

endmodule

`default_nettype wire

/* verif/tb_mastermind.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_mastermind
    import mm_pkg::*;
();

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 4;
    localparam int IDLE_CYCLES  = 2;
    localparam int REPORT_DELAY = 5;   // Release edge to score_valid_o
    localparam int MAX_HOLD     = 12;
    localparam int NUM_TABLE    = 10;
    localparam int NUM_RANDOM   = 20;
    localparam int ROUND_CYCLES = RESET_CYCLES + 2 * NUM_PEGS * (MAX_HOLD + IDLE_CYCLES + 1) + 16;
    localparam longint TIMEOUT_NS =
        longint'((NUM_TABLE + NUM_RANDOM) * ROUND_CYCLES + 100) * PERIOD;

    typedef struct packed {
        peg_row_t   code;
        peg_row_t   guess;
        logic [7:0] hold;
        count_t     red;
        count_t     white;
    } round_t;

    logic                  clock;
    logic                  resetn;
    logic                  load_i;
    peg_t                  colour_i;
    seg_t [NUM_DIGITS-1:0] hex_o;
    score_t                score_o;
    logic                  score_valid_o;

    round_t   rounds [NUM_TABLE];
    seg_t     seg_table [16];
    peg_row_t entered_code;
    logic     code_valid;

    mastermind_top mastermind_top_inst (
        .clock         (clock),
        .resetn        (resetn),
        .load_i        (load_i),
        .colour_i      (colour_i),
        .hex_o         (hex_o),
        .score_o       (score_o),
        .score_valid_o (score_valid_o)
    );

    initial clock = 1'b0;
    always #(PERIOD / 2) clock = ~clock;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int got, input int expected);
        assert (got == expected) else begin
            abort_run($sformatf("Mismatch at %0t ns: %s is 0x%0h, expected 0x%0h",
                                $time, name, got, expected));
        end
    endtask

    function automatic peg_row_t make_row(input int p0, input int p1, input int p2, input int p3);
        return {peg_t'(p3), peg_t'(p2), peg_t'(p1), peg_t'(p0)};
    endfunction

    function automatic round_t make_round(input int c0, input int c1, input int c2, input int c3,
                                          input int g0, input int g1, input int g2, input int g3,
                                          input int hold, input int red, input int white);
        round_t r;
        r.code  = make_row(c0, c1, c2, c3);
        r.guess = make_row(g0, g1, g2, g3);
        r.hold  = 8'(hold);
        r.red   = count_t'(red);
        r.white = count_t'(white);
        return r;
    endfunction

    // Per colour minimum over the positions that are not exact
    function automatic score_t reference_score(input peg_row_t code, input peg_row_t guess);
        int     code_cnt [8];
        int     guess_cnt [8];
        int     red;
        int     white;
        score_t s;
        red   = 0;
        white = 0;
        for (int c = 0; c < 8; c++) begin
            code_cnt[c]  = 0;
            guess_cnt[c] = 0;
        end
        for (int k = 0; k < NUM_PEGS; k++) begin
            if (code[k] == guess[k]) begin
                red++;
            end else begin
                code_cnt[code[k]]++;
                guess_cnt[guess[k]]++;
            end
        end
        for (int c = 0; c < 8; c++) begin
            white += (code_cnt[c] < guess_cnt[c]) ? code_cnt[c] : guess_cnt[c];
        end
        s.red   = count_t'(red);
        s.white = count_t'(white);
        return s;
    endfunction

    task automatic check_displays(input peg_row_t guess, input count_t red, input count_t white);
        for (int d = 0; d < NUM_PEGS; d++) begin
            check_value($sformatf("hex_o[%0d]", d), hex_o[d], seg_table[{1'b0, guess[d]}]);
        end
        check_value("hex_o[4]", hex_o[4], seg_table[{1'b0, red}]);
        check_value("hex_o[5]", hex_o[5], seg_table[{1'b0, white}]);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            check_value("score_valid_o", score_valid_o, 0);
        end
    endtask

    // Called on a falling edge, returns on the falling edge that releases the button
    task automatic press_peg(input peg_t colour, input int hold);
        colour_i = colour;
        load_i   = 1'b1;
        for (int c = 0; c < hold; c++) begin
            @(negedge clock);
            check_value("score_valid_o", score_valid_o, 0);
            colour_i = colour ^ peg_t'(c + 1);   // Must not be captured
        end
        load_i = 1'b0;
    endtask

    task automatic reset_dut();
        resetn   = 1'b0;
        load_i   = 1'b0;
        colour_i = '0;
        repeat (RESET_CYCLES) @(negedge clock);
        resetn = 1'b1;
        check_value("score_valid_o", score_valid_o, 0);
        check_value("score_o", score_o, 0);
        for (int d = 0; d < NUM_DIGITS; d++) begin
            check_value($sformatf("hex_o[%0d]", d), hex_o[d], seg_table[0]);
        end
    endtask

    task automatic enter_code(input peg_row_t code, input int hold);
        reset_dut();
        for (int k = 0; k < NUM_PEGS; k++) begin
            press_peg(code[k], hold);
            idle(IDLE_CYCLES);
        end
        entered_code = code;
        code_valid   = 1'b1;
    endtask

    task automatic play_guess(input peg_row_t guess, input int hold,
                              input count_t red, input count_t white);
        int cycles;
        for (int k = 0; k < NUM_PEGS; k++) begin
            press_peg(guess[k], hold);
            if (k < NUM_PEGS - 1) begin
                idle(IDLE_CYCLES);
            end
        end
        cycles = 0;
        while (!score_valid_o) begin
            @(negedge clock);
            cycles++;
            if (cycles > 4 * REPORT_DELAY) begin
                abort_run("score_valid_o never pulsed after the last guess peg was released");
            end
        end
        check_value("score_valid_o delay", cycles, REPORT_DELAY);
        check_value("score_o.red", score_o.red, red);
        check_value("score_o.white", score_o.white, white);
        check_displays(guess, red, white);
        @(negedge clock);
        check_value("score_valid_o", score_valid_o, 0);   // One cycle only
    endtask

    task automatic run_round(input peg_row_t code, input peg_row_t guess, input int hold,
                             input count_t red, input count_t white);
        if (!code_valid || code != entered_code) begin
            enter_code(code, hold);
        end
        play_guess(guess, hold, red, white);
    endtask

    initial begin
        round_t   r;
        peg_row_t code;
        peg_row_t guess;
        score_t   expected;
        int       hold;

        resetn     = 1'b0;
        load_i     = 1'b0;
        colour_i   = '0;
        code_valid = 1'b0;
        void'($urandom(32'h5abe079a));

        seg_table = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                      7'h00, 7'h18, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};

        // Code pegs, guess pegs, hold cycles, red, white
        rounds[0] = make_round(1, 2, 3, 4,  1, 2, 3, 4,   1, 4, 0);
        rounds[1] = make_round(1, 2, 3, 4,  4, 3, 2, 1,   3, 0, 4);
        rounds[2] = make_round(1, 2, 3, 4,  5, 6, 7, 0,   2, 0, 0);
        rounds[3] = make_round(1, 2, 3, 4,  1, 1, 1, 1,   1, 1, 0);
        rounds[4] = make_round(5, 5, 2, 2,  2, 2, 5, 5,   6, 0, 4);
        rounds[5] = make_round(5, 5, 2, 2,  5, 2, 2, 5,   1, 2, 2);
        rounds[6] = make_round(0, 0, 0, 7,  7, 0, 0, 0,  10, 2, 2);
        rounds[7] = make_round(0, 0, 0, 7,  0, 7, 7, 7,   1, 2, 0);
        rounds[8] = make_round(6, 3, 6, 3,  3, 3, 6, 6,   4, 2, 2);
        rounds[9] = make_round(6, 3, 6, 3,  6, 6, 6, 6,   2, 2, 0);

        reset_dut();

        for (int i = 0; i < NUM_TABLE; i++) begin
            r = rounds[i];
            run_round(r.code, r.guess, r.hold, r.red, r.white);
        end

        // A new code every fourth round and guesses that often borrow code colours
        code = '0;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            if (i % 4 == 0) begin
                code = peg_row_t'($urandom);
            end
            for (int k = 0; k < NUM_PEGS; k++) begin
                if ($urandom_range(1, 0) == 1) begin
                    guess[k] = code[$urandom_range(NUM_PEGS - 1, 0)];
                end else begin
                    guess[k] = peg_t'($urandom);
                end
            end
            hold     = $urandom_range(MAX_HOLD, 1);
            expected = reference_score(code, guess);
            run_round(code, guess, hold, expected.red, expected.white);
        end

        $display("Regression passed");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        abort_run("Watchdog expired before all rounds were played");
    end

endmodule

`default_nettype wire

/* compile.f */
verilog/mm_pkg.sv
verilog/mm_seven_seg.sv
verilog/mm_control.sv
verilog/mm_peg_regs.sv
verilog/mm_scorer.sv
verilog/mastermind_top.sv
verif/tb_mastermind.sv

/* Bender.yml */
package:
  name: mastermind

sources:
  - files:
      - verilog/mm_pkg.sv
      - verilog/mm_seven_seg.sv
      - verilog/mm_control.sv
      - verilog/mm_peg_regs.sv
      - verilog/mm_scorer.sv
      - verilog/mastermind_top.sv
  - target: simulation
    files:
      - verif/tb_mastermind.sv
